// File: hdl/zx_defines.svh
/*
 * Fixed addresses and sizes of the ZX81 memory and I/O subsystem.
 * Trap addresses match the ZX81 ROM load routine only.
 */
`ifndef ZX_DEFINES_SVH
`define ZX_DEFINES_SVH

// ============================================================
// Tape loader
// ============================================================

// M1 fetch here starts the fast loader
`define ZX_TRAP_ADDR  16'h0347
// M1 fetch at or above this ends the loader
`define ZX_TRAP_END   16'h03C3
// First .p image byte lands here
`define ZX_TAPE_BASE  16'h4009
`define ZX_PATCH_LEN  16'd7
`define ZX_TAPE_DEPTH 16384

// ============================================================
// I/O
// ============================================================
`define ZX_ZXP_PORT   16'hE007

`endif

// File: hdl/zx_pkg.sv
/*
 * Shared types for the ZX81 memory and I/O subsystem.
 * Keyboard bits are active low, joystick bits active high.
 */
package zx_pkg;

	// ============================================================
	// Bus and memory
	// ============================================================
	typedef logic [15:0] zx_addr_t;
	typedef logic [7:0]  zx_byte_t;
	typedef logic [15:0] zx_ram_addr_t;
	typedef logic [13:0] zx_tape_addr_t;

	// 0 = 1K, 1 = 16K, 2 = 32K, 3 = 48K
	typedef logic [1:0]  zx_mem_size_t;

	// ============================================================
	// Input devices
	// ============================================================
	typedef logic [4:0]  zx_keys_t;
	// Bit 0 right, 1 left, 2 down, 3 up, 4 fire
	typedef logic [4:0]  zx_joy_t;

	// Fast tape loader states
	typedef enum logic [1:0] {
		IDLE,
		COPY,
		DONE
	} zx_loader_state_t;

endpackage

// File: hdl/zx_ram_map.sv
/*
 * Main RAM mapping for 1K/16K/32K/48K; size code is sampled only while reset is high.
 * Single port array, one cycle read latency. Reads follow the write address while loading.
 */
module zx_ram_map (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  zx_pkg::zx_mem_size_t mem_size,
	input  zx_pkg::zx_addr_t     addr,
	input  logic                 m1_n,
	input  zx_pkg::zx_ram_addr_t ram_wr_addr,
	input  zx_pkg::zx_byte_t     ram_wr_data,
	input  logic                 ram_we,
	input  logic                 loader_active,
	output zx_pkg::zx_ram_addr_t ram_cpu_addr,
	output logic                 ram_cpu_en,
	output zx_pkg::zx_byte_t     ram_q
);
	import zx_pkg::*;

	zx_mem_size_t mem_size_q;
	zx_ram_addr_t rd_addr;
	zx_byte_t     ram_mem [0:(2 ** $bits(zx_ram_addr_t)) - 1];

	// ============================================================
	// Size latch
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mem_size_q <= mem_size;
		end
	end

	// ============================================================
	// CPU address translation
	// ============================================================

	// 4000h-7FFFh and C000h-FFFFh always, 8000h-BFFFh from 32K up
	assign ram_cpu_en = addr[14] | (addr[15] & mem_size_q[1]);

	always_comb begin
		case (mem_size_q)
			2'd0: begin
				// 1K mirrors over the whole window
				ram_cpu_addr = {6'b010000, addr[9:0]};
			end
			2'd1: begin
				ram_cpu_addr = {2'b01, addr[13:0]};
			end
			2'd2: begin
				if (addr[15:14] == 2'b10) begin
					ram_cpu_addr = {2'b10, addr[13:0]};
				end else begin
					// C000h block mirrors main RAM
					ram_cpu_addr = {2'b01, addr[13:0]};
				end
			end
			default: begin
				if (addr[15:14] == 2'b10) begin
					ram_cpu_addr = {2'b10, addr[13:0]};
				end else if (addr[15:14] == 2'b11) begin
					// Upper 16K for data only, opcodes fetched from main RAM
					ram_cpu_addr = {m1_n, 1'b1, addr[13:0]};
				end else begin
					ram_cpu_addr = {2'b01, addr[13:0]};
				end
			end
		endcase
	end

	// ============================================================
	// RAM array
	// ============================================================
	assign rd_addr = loader_active ? ram_wr_addr : ram_cpu_addr;

	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			ram_mem[ram_wr_addr] <= ram_wr_data;
		end
		ram_q <= ram_mem[rd_addr];
	end

endmodule

// File: hdl/zx_tape_loader.sv
/*
 * Fast .p loader: traps the ROM load routine, serves patch bytes and copies the tape to 4009h.
 * One byte is copied per ce_cpu strobe; the size latches on the falling edge of load_active.
 */
`include "zx_defines.svh"

module zx_tape_loader (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  zx_pkg::zx_addr_t      addr,
	input  logic                  m1_n,
	input  logic                  ce_cpu,
	input  logic                  load_active,
	input  logic                  load_wr,
	input  zx_pkg::zx_tape_addr_t load_addr,
	input  zx_pkg::zx_byte_t      load_data,
	output logic                  loader_active,
	output logic                  loader_we,
	output zx_pkg::zx_ram_addr_t  loader_addr,
	output zx_pkg::zx_byte_t      loader_data,
	output zx_pkg::zx_byte_t      patch_byte,
	output logic                  tape_ready
);
	import zx_pkg::*;

	zx_byte_t         tape_ram [0:`ZX_TAPE_DEPTH - 1];
	zx_tape_addr_t    tape_size;
	zx_tape_addr_t    tape_idx;
	zx_loader_state_t state;
	zx_byte_t         patch_1;
	zx_addr_t         trap_off;
	logic             m1_n_q;
	logic             load_active_q;
	logic             m1_fall;
	logic             copy_step;

	assign tape_ready    = |tape_size;
	assign loader_active = (state != IDLE);
	assign m1_fall       = m1_n_q & ~m1_n;
	assign copy_step     = (state == COPY) & ce_cpu & (tape_idx < tape_size);

	// ============================================================
	// Tape buffer and copy data path
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (load_active & load_wr) begin
			tape_ram[load_addr] <= load_data;
		end
		if (copy_step) begin
			loader_data <= tape_ram[tape_idx];
			loader_addr <= `ZX_TAPE_BASE + {2'b00, tape_idx};
		end
	end

	// ============================================================
	// Trap detection and copy sequencing
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state         <= IDLE;
			tape_size     <= '0;
			tape_idx      <= '0;
			patch_1       <= 8'h00;
			loader_we     <= 1'b0;
			m1_n_q        <= 1'b1;
			load_active_q <= 1'b0;
		end else begin
			m1_n_q        <= m1_n;
			load_active_q <= load_active;
			loader_we     <= copy_step;

			// End of download, load_addr holds the byte count
			if (load_active_q & ~load_active) begin
				tape_size <= load_addr;
			end

			if (m1_fall) begin
				if (addr == `ZX_TRAP_ADDR && tape_ready && state == IDLE) begin
					state    <= COPY;
					tape_idx <= '0;
					// NOP keeps the patch loop spinning
					patch_1  <= 8'h00;
				end else if (addr >= `ZX_TRAP_END || addr < `ZX_TRAP_ADDR) begin
					state <= IDLE;
				end
			end else if (state == COPY && ce_cpu) begin
				if (tape_idx < tape_size) begin
					tape_idx <= tape_idx + 14'd1;
				end else begin
					state   <= DONE;
					// SCF lets the loop fall through to the ROM
					patch_1 <= 8'h37;
				end
			end
		end
	end

	// ============================================================
	// Patch routine
	// ============================================================

	// xor a / nop or scf / jr nc,-3 / jp 0207h
	assign trap_off = addr - `ZX_TRAP_ADDR;

	always_comb begin
		case (trap_off)
			16'd0:   patch_byte = 8'hAF;
			16'd1:   patch_byte = patch_1;
			16'd2:   patch_byte = 8'h30;
			16'd3:   patch_byte = 8'hFD;
			16'd4:   patch_byte = 8'hC3;
			16'd5:   patch_byte = 8'h07;
			16'd6:   patch_byte = 8'h02;
			default: patch_byte = 8'hFF;
		endcase
	end

endmodule

// File: hdl/zx_joy_port.sv
/*
 * ZXpand joystick port at E007h and the keyboard read on even ports.
 * Sinclair joystick mapping only; bit 7 of the keyboard byte reads as 0.
 */
`include "zx_defines.svh"

module zx_joy_port (
	input  logic             clk_sys,
	input  logic             reset,
	input  zx_pkg::zx_addr_t addr,
	input  logic             iorq_n,
	input  logic             rd_n,
	input  logic             wr_n,
	input  zx_pkg::zx_byte_t cpu_dout,
	input  zx_pkg::zx_keys_t key_data,
	input  zx_pkg::zx_joy_t  joy,
	input  logic             hz50,
	output zx_pkg::zx_byte_t io_byte,
	output logic             io_sel
);
	import zx_pkg::*;

	zx_byte_t zxp_value;
	zx_keys_t joy_mask;
	logic     zxp_override;
	logic     zxp_sel;
	logic     kbd_sel;

	assign zxp_sel = ~iorq_n & (addr == `ZX_ZXP_PORT);
	assign kbd_sel = ~iorq_n & ~rd_n & ~addr[0];
	assign io_sel  = kbd_sel | (zxp_sel & ~rd_n);

	// ============================================================
	// ZXpand command register
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			zxp_value    <= 8'hFF;
			zxp_override <= 1'b0;
		end else if (zxp_sel & ~wr_n) begin
			case (cpu_dout)
				8'hAA: zxp_value <= 8'hF0;
				8'h55: zxp_value <= 8'h0F;
				8'hA0: begin
					// Up, down, left, right, fire, active low
					zxp_value    <= {~joy[3:0], ~joy[4], 3'b000};
					zxp_override <= 1'b1;
				end
				default: zxp_value <= 8'hFF;
			endcase
		end
	end

	// ============================================================
	// Read value
	// ============================================================

	// Sinclair 1 joystick on keys 6-0, only on the row with A12 low
	assign joy_mask = (zxp_override | addr[12]) ? 5'b11111 :
		~{joy[1], joy[0], joy[2], joy[3], joy[4]};

	assign io_byte = kbd_sel ? {1'b0, hz50, 1'b0, key_data & joy_mask} : zxp_value;

endmodule

// File: hdl/zx_bus_arbiter.sv
/*
 * Owns the RAM write port and the CPU read byte; CPU writes are dropped while loading.
 * cpu_din is valid two clk_sys edges after the bus is stable.
 */
`include "zx_defines.svh"

module zx_bus_arbiter (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  zx_pkg::zx_addr_t     addr,
	input  logic                 mreq_n,
	input  logic                 iorq_n,
	input  logic                 rd_n,
	input  logic                 wr_n,
	input  zx_pkg::zx_byte_t     cpu_dout,
	input  logic                 loader_active,
	input  logic                 loader_we,
	input  zx_pkg::zx_ram_addr_t loader_addr,
	input  zx_pkg::zx_byte_t     loader_data,
	input  zx_pkg::zx_byte_t     patch_byte,
	input  zx_pkg::zx_ram_addr_t ram_cpu_addr,
	input  logic                 ram_cpu_en,
	input  zx_pkg::zx_byte_t     ram_q,
	input  zx_pkg::zx_byte_t     io_byte,
	input  logic                 io_sel,
	output zx_pkg::zx_ram_addr_t ram_wr_addr,
	output zx_pkg::zx_byte_t     ram_wr_data,
	output logic                 ram_we,
	output zx_pkg::zx_byte_t     cpu_din
);
	import zx_pkg::*;

	zx_addr_t trap_off;
	logic     mem_rd;
	logic     io_rd;
	logic     sel_patch_q;
	logic     sel_ram_q;
	logic     sel_io_q;

	assign mem_rd   = ~mreq_n & ~rd_n;
	assign io_rd    = ~iorq_n & ~rd_n;
	assign trap_off = addr - `ZX_TRAP_ADDR;

	// ============================================================
	// RAM write port
	// ============================================================
	assign ram_we      = loader_active ? loader_we : (~mreq_n & ~wr_n & ram_cpu_en);
	assign ram_wr_addr = loader_active ? loader_addr : ram_cpu_addr;
	assign ram_wr_data = loader_active ? loader_data : cpu_dout;

	// ============================================================
	// Read path
	// ============================================================

	// Stage 1 picks the source while the RAM read is in flight
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sel_patch_q <= 1'b0;
			sel_ram_q   <= 1'b0;
			sel_io_q    <= 1'b0;
			cpu_din     <= 8'hFF;
		end else begin
			sel_patch_q <= mem_rd & loader_active & (trap_off < `ZX_PATCH_LEN);
			sel_ram_q   <= mem_rd & ram_cpu_en;
			sel_io_q    <= io_rd & io_sel;

			// Stage 2, priority patch, RAM, I/O, open bus
			if (sel_patch_q) begin
				cpu_din <= patch_byte;
			end else if (sel_ram_q) begin
				cpu_din <= ram_q;
			end else if (sel_io_q) begin
				cpu_din <= io_byte;
			end else begin
				cpu_din <= 8'hFF;
			end
		end
	end

endmodule

// File: hdl/zx_mem_io.sv
/*
 * ZX81 memory and I/O subsystem seen from the Z80 bus; the CPU itself is outside.
 * Bus strobes are active low and never stalled.
 */
module zx_mem_io (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  zx_pkg::zx_addr_t      addr,
	input  zx_pkg::zx_byte_t      cpu_dout,
	input  logic                  m1_n,
	input  logic                  mreq_n,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic                  ce_cpu,
	input  zx_pkg::zx_mem_size_t  mem_size,
	input  zx_pkg::zx_keys_t      key_data,
	input  zx_pkg::zx_joy_t       joy,
	input  logic                  hz50,
	input  logic                  load_active,
	input  logic                  load_wr,
	input  zx_pkg::zx_tape_addr_t load_addr,
	input  zx_pkg::zx_byte_t      load_data,
	output zx_pkg::zx_byte_t      cpu_din,
	output logic                  tape_ready
);
	import zx_pkg::*;

	zx_ram_addr_t ram_cpu_addr;
	zx_ram_addr_t ram_wr_addr;
	zx_ram_addr_t loader_addr;
	zx_byte_t     ram_wr_data;
	zx_byte_t     ram_q;
	zx_byte_t     loader_data;
	zx_byte_t     patch_byte;
	zx_byte_t     io_byte;
	logic         ram_cpu_en;
	logic         ram_we;
	logic         loader_active;
	logic         loader_we;
	logic         io_sel;

	zx_ram_map ram_map_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.mem_size      (mem_size),
		.addr          (addr),
		.m1_n          (m1_n),
		.ram_wr_addr   (ram_wr_addr),
		.ram_wr_data   (ram_wr_data),
		.ram_we        (ram_we),
		.loader_active (loader_active),
		.ram_cpu_addr  (ram_cpu_addr),
		.ram_cpu_en    (ram_cpu_en),
		.ram_q         (ram_q)
	);

	zx_tape_loader tape_loader_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.addr          (addr),
		.m1_n          (m1_n),
		.ce_cpu        (ce_cpu),
		.load_active   (load_active),
		.load_wr       (load_wr),
		.load_addr     (load_addr),
		.load_data     (load_data),
		.loader_active (loader_active),
		.loader_we     (loader_we),
		.loader_addr   (loader_addr),
		.loader_data   (loader_data),
		.patch_byte    (patch_byte),
		.tape_ready    (tape_ready)
	);

	zx_joy_port joy_port_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.addr     (addr),
		.iorq_n   (iorq_n),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.cpu_dout (cpu_dout),
		.key_data (key_data),
		.joy      (joy),
		.hz50     (hz50),
		.io_byte  (io_byte),
		.io_sel   (io_sel)
	);

	zx_bus_arbiter bus_arbiter_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.addr          (addr),
		.mreq_n        (mreq_n),
		.iorq_n        (iorq_n),
		.rd_n          (rd_n),
		.wr_n          (wr_n),
		.cpu_dout      (cpu_dout),
		.loader_active (loader_active),
		.loader_we     (loader_we),
		.loader_addr   (loader_addr),
		.loader_data   (loader_data),
		.patch_byte    (patch_byte),
		.ram_cpu_addr  (ram_cpu_addr),
		.ram_cpu_en    (ram_cpu_en),
		.ram_q         (ram_q),
		.io_byte       (io_byte),
		.io_sel        (io_sel),
		.ram_wr_addr   (ram_wr_addr),
		.ram_wr_data   (ram_wr_data),
		.ram_we        (ram_we),
		.cpu_din       (cpu_din)
	);

endmodule

// File: bench/tb_zx_mem_io.sv
/*
 * Testbench for zx_mem_io. Bus inputs change on the falling clk_sys edge.
 * RAM is only read back at addresses that were written earlier in the run.
 */
`include "zx_defines.svh"

module tb_zx_mem_io;
	import zx_pkg::*;

	logic          clk_sys;
	logic          reset;
	zx_addr_t      addr;
	zx_byte_t      cpu_dout;
	logic          m1_n;
	logic          mreq_n;
	logic          iorq_n;
	logic          rd_n;
	logic          wr_n;
	logic          ce_cpu;
	zx_mem_size_t  mem_size;
	zx_keys_t      key_data;
	zx_joy_t       joy;
	logic          hz50;
	logic          load_active;
	logic          load_wr;
	zx_tape_addr_t load_addr;
	zx_byte_t      load_data;
	zx_byte_t      cpu_din;
	logic          tape_ready;

	integer       seed = 18;
	zx_mem_size_t cur_size;
	zx_byte_t     rd_q;
	zx_byte_t     model_ram [0:65535];
	zx_byte_t     tape_bytes [0:63];
	zx_byte_t     zxp_cmds [0:3] = '{8'hAA, 8'h55, 8'h5A, 8'hA0};

	// Pending comparisons queued by the tests and drained by the checker
	string    name_q [$];
	zx_byte_t exp_q [$];
	zx_byte_t act_q [$];
	bit       kind_q [$];
	string    cmp_name;
	zx_byte_t cmp_exp;
	zx_byte_t cmp_act;
	bit       cmp_kind;

	zx_mem_io dut_i (.*);

	always #4 clk_sys = ~clk_sys;

	// ============================================================
	// Reference model
	// ============================================================
	function automatic logic [31:0] next_rand();
		next_rand = $random(seed);
	endfunction

	function automatic bit map_enabled(input zx_addr_t a, input zx_mem_size_t size);
		if (a < 16'h4000) begin
			map_enabled = 1'b0;
		end else if (a >= 16'h8000 && a < 16'hC000) begin
			map_enabled = (size >= 2'd2);
		end else begin
			map_enabled = 1'b1;
		end
	endfunction

	function automatic zx_ram_addr_t map_phys(input zx_addr_t a, input bit m1,
			input zx_mem_size_t size);
		zx_ram_addr_t low14;
		low14 = {2'b00, a[13:0]};
		// Main RAM unless a higher block claims the address
		map_phys = 16'h4000 + low14;
		if (size == 2'd0) begin
			map_phys = 16'h4000 + {6'd0, a[9:0]};
		end else if (size >= 2'd2 && a >= 16'h8000 && a < 16'hC000) begin
			map_phys = 16'h8000 + low14;
		end else if (size == 2'd3 && a >= 16'hC000 && !m1) begin
			map_phys = 16'hC000 + low14;
		end
	endfunction

	function automatic zx_byte_t expected_mem_read(input zx_addr_t a, input bit m1);
		if (map_enabled(a, cur_size)) begin
			expected_mem_read = model_ram[map_phys(a, m1, cur_size)];
		end else begin
			expected_mem_read = 8'hFF;
		end
	endfunction

	function automatic zx_byte_t expected_key_read(input zx_keys_t keys, input zx_joy_t j,
			input bit hz, input bit a12, input bit override);
		zx_keys_t mask;
		mask = 5'b11111;
		if (!override && !a12) begin
			// Left, right, down, up, fire onto bits 4 to 0
			mask = {~j[1], ~j[0], ~j[2], ~j[3], ~j[4]};
		end
		expected_key_read = {1'b0, hz, 1'b0, keys & mask};
	endfunction

	function automatic zx_byte_t expected_zxp(input zx_byte_t cmd, input zx_joy_t j);
		case (cmd)
			8'hAA:   expected_zxp = 8'hF0;
			8'h55:   expected_zxp = 8'h0F;
			8'hA0:   expected_zxp = {~j[3], ~j[2], ~j[1], ~j[0], ~j[4], 3'b000};
			default: expected_zxp = 8'hFF;
		endcase
	endfunction

	function automatic zx_byte_t expected_patch(input int k, input bit done);
		case (k)
			0:       expected_patch = 8'hAF;
			1:       expected_patch = done ? 8'h37 : 8'h00;
			2:       expected_patch = 8'h30;
			3:       expected_patch = 8'hFD;
			4:       expected_patch = 8'hC3;
			5:       expected_patch = 8'h07;
			default: expected_patch = 8'h02;
		endcase
	endfunction

	// ============================================================
	// Checks
	// ============================================================
	task automatic check_byte(input string name, input zx_byte_t e, input zx_byte_t a);
		if (e !== a) begin
			$display("error %s: expected %02h, actual %02h", name, e, a);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic check_flag(input string name, input bit e, input bit a);
		if (e !== a) begin
			$display("error %s: expected %0b, actual %0b", name, e, a);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("timeout: %s", what);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic expect_byte(input string name, input zx_byte_t e, input zx_byte_t a);
		name_q.push_back(name);
		exp_q.push_back(e);
		act_q.push_back(a);
		kind_q.push_back(1'b0);
	endtask

	task automatic expect_flag(input string name, input bit e, input bit a);
		name_q.push_back(name);
		exp_q.push_back({7'd0, e});
		act_q.push_back({7'd0, a});
		kind_q.push_back(1'b1);
	endtask

	always @(negedge clk_sys) begin
		while (exp_q.size() != 0) begin
			cmp_name = name_q.pop_front();
			cmp_exp  = exp_q.pop_front();
			cmp_act  = act_q.pop_front();
			cmp_kind = kind_q.pop_front();
			if (cmp_kind) begin
				check_flag(cmp_name, cmp_exp[0], cmp_act[0]);
			end else begin
				check_byte(cmp_name, cmp_exp, cmp_act);
			end
		end
	end

	// ============================================================
	// Bus tasks
	// ============================================================
	task automatic apply_reset(input zx_mem_size_t size);
		@(negedge clk_sys);
		reset    = 1'b1;
		mem_size = size;
		repeat (8) @(negedge clk_sys);
		reset    = 1'b0;
		cur_size = size;
	endtask

	// Held for 3 clocks with read data taken after the second rising edge
	task automatic bus_cycle(input zx_addr_t a, input zx_byte_t d, input bit io,
			input bit wr, input bit m1, output zx_byte_t q);
		@(negedge clk_sys);
		addr     = a;
		cpu_dout = d;
		m1_n     = ~m1;
		mreq_n   = io;
		iorq_n   = ~io;
		rd_n     = wr;
		wr_n     = ~wr;
		@(posedge clk_sys);
		@(posedge clk_sys);
		@(negedge clk_sys);
		q = cpu_din;
		@(posedge clk_sys);
		@(negedge clk_sys);
		m1_n   = 1'b1;
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
	endtask

	// ============================================================
	// Tests
	// ============================================================
	initial begin
		logic [31:0] r;
		zx_addr_t    a;
		zx_addr_t    wa [0:15];
		int          n;
		int          polls;

		clk_sys     = 1'b0;
		reset       = 1'b1;
		addr        = 16'h0000;
		cpu_dout    = 8'h00;
		m1_n        = 1'b1;
		mreq_n      = 1'b1;
		iorq_n      = 1'b1;
		rd_n        = 1'b1;
		wr_n        = 1'b1;
		ce_cpu      = 1'b0;
		mem_size    = 2'd0;
		key_data    = 5'b11111;
		joy         = 5'b00000;
		hz50        = 1'b0;
		load_active = 1'b0;
		load_wr     = 1'b0;
		load_addr   = '0;
		load_data   = 8'h00;

		// Random write and readback for every RAM size
		for (int s = 0; s < 4; s++) begin
			apply_reset(zx_mem_size_t'(s));
			for (int i = 0; i < 16; i++) begin
				r     = next_rand();
				wa[i] = r[15:0];
				if (!map_enabled(wa[i], cur_size)) begin
					wa[i][14] = 1'b1;
				end
				model_ram[map_phys(wa[i], 1'b0, cur_size)] = r[23:16];
				bus_cycle(wa[i], r[23:16], 1'b0, 1'b1, 1'b0, rd_q);
			end
			for (int i = 0; i < 16; i++) begin
				bus_cycle(wa[i], 8'h00, 1'b0, 1'b0, 1'b0, rd_q);
				expect_byte("ram readback", expected_mem_read(wa[i], 1'b0), rd_q);
			end
			// Main RAM byte seen again through the C000h window
			model_ram[map_phys(16'h5ABC, 1'b0, cur_size)] = r[31:24];
			bus_cycle(16'h5ABC, r[31:24], 1'b0, 1'b1, 1'b0, rd_q);
			bus_cycle(16'hDABC, 8'h00, 1'b0, 1'b0, 1'b1, rd_q);
			expect_byte("c000h mirror", expected_mem_read(16'hDABC, 1'b1), rd_q);
		end

		// 48K upper block against opcode fetch
		model_ram[map_phys(16'hC123, 1'b0, cur_size)] = 8'h5A;
		bus_cycle(16'hC123, 8'h5A, 1'b0, 1'b1, 1'b0, rd_q);
		model_ram[map_phys(16'h4123, 1'b0, cur_size)] = 8'hA5;
		bus_cycle(16'h4123, 8'hA5, 1'b0, 1'b1, 1'b0, rd_q);
		bus_cycle(16'hC123, 8'h00, 1'b0, 1'b0, 1'b1, rd_q);
		expect_byte("48k m1 read", expected_mem_read(16'hC123, 1'b1), rd_q);
		bus_cycle(16'hC123, 8'h00, 1'b0, 1'b0, 1'b0, rd_q);
		expect_byte("48k data read", expected_mem_read(16'hC123, 1'b0), rd_q);

		// Open bus for ROM area and unselected odd ports
		for (int i = 0; i < 8; i++) begin
			r = next_rand();
			a = {2'b00, r[13:0]};
			bus_cycle(a, 8'h00, 1'b0, 1'b0, 1'b0, rd_q);
			expect_byte("rom area read", expected_mem_read(a, 1'b0), rd_q);
			a = r[31:16] | 16'h0001;
			if (a == `ZX_ZXP_PORT) begin
				a = 16'hE005;
			end
			bus_cycle(a, 8'h00, 1'b1, 1'b0, 1'b0, rd_q);
			expect_byte("odd port read", 8'hFF, rd_q);
		end

		// Keyboard with Sinclair joystick masking
		for (int i = 0; i < 16; i++) begin
			r        = next_rand();
			key_data = r[4:0];
			joy      = r[9:5];
			hz50     = r[10];
			a        = {r[31:17], 1'b0};
			bus_cycle(a, 8'h00, 1'b1, 1'b0, 1'b0, rd_q);
			expect_byte("keyboard read",
				expected_key_read(key_data, joy, hz50, a[12], 1'b0), rd_q);
		end

		// ZXpand port commands
		joy = 5'b00011;
		bus_cycle(`ZX_ZXP_PORT, 8'h00, 1'b1, 1'b0, 1'b0, rd_q);
		expect_byte("zxpand after reset", 8'hFF, rd_q);
		for (int i = 0; i < 4; i++) begin
			bus_cycle(`ZX_ZXP_PORT, zxp_cmds[i], 1'b1, 1'b1, 1'b0, rd_q);
			bus_cycle(`ZX_ZXP_PORT, 8'h00, 1'b1, 1'b0, 1'b0, rd_q);
			expect_byte("zxpand readback", expected_zxp(zxp_cmds[i], joy), rd_q);
		end
		for (int i = 0; i < 4; i++) begin
			r        = next_rand();
			key_data = r[4:0] | 5'b01000;
			joy      = r[9:5] | 5'b00001;
			a        = {r[31:29], 1'b0, r[27:17], 1'b0};
			bus_cycle(a, 8'h00, 1'b1, 1'b0, 1'b0, rd_q);
			expect_byte("keyboard override",
				expected_key_read(key_data, joy, hz50, a[12], 1'b1), rd_q);
		end

		// Tape download, trap, copy and RAM contents
		apply_reset(2'd1);
		expect_flag("tape ready after reset", 1'b0, tape_ready);
		r = next_rand();
		n = 16 + int'(r[4:0]);
		@(negedge clk_sys);
		load_active = 1'b1;
		for (int k = 0; k < n; k++) begin
			r             = next_rand();
			tape_bytes[k] = r[7:0];
			load_addr     = zx_tape_addr_t'(k);
			load_data     = r[7:0];
			load_wr       = 1'b1;
			@(negedge clk_sys);
			load_wr       = 1'b0;
			@(negedge clk_sys);
		end
		expect_flag("tape ready during download", 1'b0, tape_ready);
		load_addr = zx_tape_addr_t'(n);
		@(negedge clk_sys);
		load_active = 1'b0;
		polls = 0;
		while (tape_ready !== 1'b1) begin
			if (polls == 10) begin
				timeout_fail("tape_ready stayed low after the download");
			end
			@(negedge clk_sys);
			polls++;
		end

		bus_cycle(`ZX_TRAP_ADDR, 8'h00, 1'b0, 1'b0, 1'b1, rd_q);
		for (int k = 0; k < int'(`ZX_PATCH_LEN); k++) begin
			bus_cycle(`ZX_TRAP_ADDR + zx_addr_t'(k), 8'h00, 1'b0, 1'b0, 1'b0, rd_q);
			expect_byte("patch byte", expected_patch(k, 1'b0), rd_q);
		end

		// One ce_cpu strobe per poll until the patch loop is released
		polls = 0;
		rd_q  = 8'h00;
		while (rd_q !== 8'h37) begin
			if (polls == 2 * n + 16) begin
				timeout_fail("tape copy did not finish");
			end
			@(negedge clk_sys);
			ce_cpu = 1'b1;
			@(negedge clk_sys);
			ce_cpu = 1'b0;
			bus_cycle(`ZX_TRAP_ADDR + 16'd1, 8'h00, 1'b0, 1'b0, 1'b0, rd_q);
			if (rd_q !== 8'h37) begin
				expect_byte("patch while copying", expected_patch(1, 1'b0), rd_q);
			end
			polls++;
		end
		for (int k = 0; k < int'(`ZX_PATCH_LEN); k++) begin
			bus_cycle(`ZX_TRAP_ADDR + zx_addr_t'(k), 8'h00, 1'b0, 1'b0, 1'b0, rd_q);
			expect_byte("patch after copy", expected_patch(k, 1'b1), rd_q);
		end

		bus_cycle(16'h0200, 8'h00, 1'b0, 1'b0, 1'b1, rd_q);
		expect_byte("loader exit fetch", expected_mem_read(16'h0200, 1'b1), rd_q);
		for (int k = 0; k < n; k++) begin
			a = `ZX_TAPE_BASE + zx_addr_t'(k);
			model_ram[map_phys(a, 1'b0, cur_size)] = tape_bytes[k];
			bus_cycle(a, 8'h00, 1'b0, 1'b0, 1'b0, rd_q);
			expect_byte("tape copy", expected_mem_read(a, 1'b0), rd_q);
		end

		polls = 0;
		while (exp_q.size() != 0) begin
			if (polls == 10) begin
				timeout_fail("pending checks were not compared");
			end
			@(negedge clk_sys);
			polls++;
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

// File: compile.f
+incdir+hdl
hdl/zx_pkg.sv
hdl/zx_ram_map.sv
hdl/zx_tape_loader.sv
hdl/zx_joy_port.sv
hdl/zx_bus_arbiter.sv
hdl/zx_mem_io.sv
bench/tb_zx_mem_io.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it, exit status reports the result
cd "$(dirname "$0")" \
	&& verilator --binary --timing --top-module tb_zx_mem_io -f compile.f -o sim_zx_mem_io \
	&& ./obj_dir/sim_zx_mem_io \
	|| exit 1
